// ==== hw/bus_map_pkg.sv ====
/*
 * shared definitions for the mapped strobe bus
 * holds the widths, the address map, the register indices and the structs
 * that carry requests, responses, target strobes and timer settings
 */
package bus_map_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------

    localparam int addr_width  = 12;
    localparam int data_width  = 16;
    // wide enough for the largest region, which is the 16-word RAM
    localparam int index_width = 4;

    // ------------------------------------------------------------------
    // address map, base and bound are both inclusive
    // ------------------------------------------------------------------

    localparam logic [addr_width-1:0] ram_base    = 12'h100;
    localparam logic [addr_width-1:0] ram_bound   = 12'h10F;
    localparam logic [addr_width-1:0] reg_base    = 12'h200;
    localparam logic [addr_width-1:0] reg_bound   = 12'h203;
    // the timer is a single word so base and bound coincide
    localparam logic [addr_width-1:0] timer_base  = 12'h300;
    localparam logic [addr_width-1:0] timer_bound = 12'h300;

    // word indices inside the register region, after translation
    localparam logic [index_width-1:0] reg_timer_ctrl   = 4'd0;
    localparam logic [index_width-1:0] reg_timer_reload = 4'd1;
    localparam logic [index_width-1:0] reg_status       = 4'd2;
    localparam logic [index_width-1:0] reg_scratch      = 4'd3;

    // ------------------------------------------------------------------
    // structs
    // ------------------------------------------------------------------

    // one request as the master presents it alongside the req strobe
    typedef struct packed {
        logic                  write;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
    } bus_request_t;

    // one completed access, valid only while rsp_valid is high
    typedef struct packed {
        logic [data_width-1:0] rdata;
        logic                  err;
    } bus_response_t;

    // strobes and operands for a single target, all zero when idle
    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [index_width-1:0] index;
        logic [data_width-1:0]  wdata;
    } target_access_t;

    // timer settings as software leaves them in the control registers
    typedef struct packed {
        logic                  enable;
        logic                  reload_mode;
        logic [data_width-1:0] reload_value;
    } timer_config_t;

endpackage

// ==== hw/memory_mapper.sv ====
/*
 * registered region decoder
 * flags a hit when the address lies within base and bound and turns the
 * low address bits into a zero-based word index for the target
 */
module memory_mapper
    import bus_map_pkg::*;
#(
    parameter logic [addr_width-1:0] addr_base  = '0,
    parameter logic [addr_width-1:0] addr_bound = '0
) (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   enable,
    input  logic [addr_width-1:0]  addr,
    output logic [index_width-1:0] index,
    output logic                   hit
);

    logic                   in_range;
    logic [index_width-1:0] translated;

    // the full address is compared so aliases above the region never hit
    assign in_range = enable && (addr >= addr_base) && (addr <= addr_bound);

    // only the low bits differ inside a region, so subtracting the low bits
    // of the base is enough to give a zero-based index
    assign translated = addr[index_width-1:0] - addr_base[index_width-1:0];

    // hit is control state and must come out of reset low
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            hit <= 1'b0;
        end else begin
            hit <= in_range;
        end
    end

    // the index is registered on the same edge as hit so the two line up
    // a miss leaves the index at zero, which lets the top level OR the
    // index buses of all mappers without a multiplexer
    always_ff @(posedge clock) begin
        if (in_range) begin
            index <= translated;
        end else begin
            index <= '0;
        end
    end

endmodule

// ==== hw/access_sequencer.sv ====
/*
 * access sequencer for the strobe bus
 * captures one request, runs it through the mappers, strobes the target that
 * hit and returns a single response pulse a fixed three cycles later
 */
module access_sequencer
    import bus_map_pkg::*;
(
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   req,
    input  bus_request_t           request,
    output logic                   busy,
    output logic                   lookup_enable,
    output logic [addr_width-1:0]  lookup_addr,
    input  logic                   ram_hit,
    input  logic                   reg_hit,
    input  logic                   timer_hit,
    input  logic [index_width-1:0] lookup_index,
    output target_access_t         ram_access,
    output target_access_t         reg_access,
    output target_access_t         timer_access,
    input  logic [data_width-1:0]  ram_rdata,
    input  logic [data_width-1:0]  reg_rdata,
    input  logic [data_width-1:0]  timer_rdata,
    output logic                   rsp_valid,
    output bus_response_t          response
);

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_access,
        st_respond
    } state_t;

    state_t                state;
    bus_request_t          req_q;
    logic                  sel_ram;
    logic                  sel_reg;
    logic                  sel_timer;
    logic                  err_q;
    logic                  in_access;
    target_access_t        hit_access;
    logic [data_width-1:0] selected_rdata;

    // ------------------------------------------------------------------
    // state machine, one cycle per state
    // ------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (req) begin
                        state <= st_lookup;
                    end
                end
                st_lookup:  state <= st_access;
                st_access:  state <= st_respond;
                default:    state <= st_idle;
            endcase
        end
    end

    // requests are only taken while idle, anything pulsed later is dropped
    assign busy = (state != st_idle);

    always_ff @(posedge clock) begin
        if (state == st_idle && req) begin
            req_q <= request;
        end
    end

    // the mappers see the held address for exactly the lookup cycle
    assign lookup_enable = (state == st_lookup);
    assign lookup_addr   = req_q.addr;

    // ------------------------------------------------------------------
    // target strobes
    // ------------------------------------------------------------------

    assign in_access = (state == st_access);

    always_comb begin
        hit_access.read  = in_access && !req_q.write;
        hit_access.write = in_access && req_q.write;
        hit_access.index = lookup_index;
        hit_access.wdata = req_q.wdata;
        // the mappers never overlap, so at most one target is strobed
        ram_access   = (in_access && ram_hit) ? hit_access : '0;
        reg_access   = (in_access && reg_hit) ? hit_access : '0;
        timer_access = (in_access && timer_hit) ? hit_access : '0;
    end

    // remember which target answered, a miss everywhere becomes the error
    always_ff @(posedge clock) begin
        if (in_access) begin
            sel_ram   <= ram_hit;
            sel_reg   <= reg_hit;
            sel_timer <= timer_hit;
            err_q     <= !(ram_hit || reg_hit || timer_hit);
        end
    end

    // ------------------------------------------------------------------
    // response
    // ------------------------------------------------------------------

    // targets return data one cycle after the strobe, which is the respond
    // cycle, and an errored access reads as zero
    assign selected_rdata = sel_ram   ? ram_rdata :
                            sel_reg   ? reg_rdata :
                            sel_timer ? timer_rdata : '0;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= (state == st_respond);
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_respond) begin
            response.rdata <= selected_rdata;
            response.err   <= err_q;
        end
    end

endmodule

// ==== hw/scratch_ram.sv ====
/*
 * scratch RAM of sixteen words
 * writes on the write strobe, read data is registered on the read strobe
 */
module scratch_ram
    import bus_map_pkg::*;
(
    input  logic                  clock,
    input  target_access_t        access,
    output logic [data_width-1:0] rdata
);

    localparam int depth = 2 ** index_width;

    logic [data_width-1:0] mem [depth];

    // contents are undefined after power up, software is expected to write
    // a word before relying on it
    always_ff @(posedge clock) begin
        if (access.write) begin
            mem[access.index] <= access.wdata;
        end
    end

    // rdata holds its value between reads
    always_ff @(posedge clock) begin
        if (access.read) begin
            rdata <= mem[access.index];
        end
    end

endmodule

// ==== hw/control_regs.sv ====
/*
 * control and status registers for the interval timer
 * holds the timer control word, the reload value, a sticky expiry flag that
 * drives irq and clears on a written one, and a free scratch word
 */
module control_regs
    import bus_map_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  target_access_t        access,
    input  logic                  expired,
    output logic [data_width-1:0] rdata,
    output timer_config_t         timer_config,
    output logic                  irq
);

    logic                  expired_flag;
    logic [data_width-1:0] scratch;
    logic                  wr_ctrl;
    logic                  wr_reload;
    logic                  wr_status;
    logic                  wr_scratch;

    assign wr_ctrl    = access.write && (access.index == reg_timer_ctrl);
    assign wr_reload  = access.write && (access.index == reg_timer_reload);
    assign wr_status  = access.write && (access.index == reg_status);
    assign wr_scratch = access.write && (access.index == reg_scratch);

    // control word, bit 0 is enable and bit 1 selects reload mode
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            timer_config.enable      <= 1'b0;
            timer_config.reload_mode <= 1'b0;
        end else if (wr_ctrl) begin
            timer_config.enable      <= access.wdata[0];
            timer_config.reload_mode <= access.wdata[1];
        end
    end

    always_ff @(posedge clock) begin
        if (wr_reload) begin
            timer_config.reload_value <= access.wdata;
        end
        if (wr_scratch) begin
            scratch <= access.wdata;
        end
    end

    // an expiry in the same cycle as the clearing write wins, so no event
    // is ever lost
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            expired_flag <= 1'b0;
        end else if (expired) begin
            expired_flag <= 1'b1;
        end else if (wr_status && access.wdata[0]) begin
            expired_flag <= 1'b0;
        end
    end

    assign irq = expired_flag;

    // ------------------------------------------------------------------
    // read back
    // ------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (access.read) begin
            case (access.index)
                reg_timer_ctrl: begin
                    rdata <= {{(data_width-2){1'b0}}, timer_config.reload_mode,
                              timer_config.enable};
                end
                reg_timer_reload: rdata <= timer_config.reload_value;
                reg_status:       rdata <= {{(data_width-1){1'b0}}, expired_flag};
                reg_scratch:      rdata <= scratch;
                default:          rdata <= '0;
            endcase
        end
    end

endmodule

// ==== hw/interval_timer.sv ====
/*
 * countdown interval timer
 * counts down once per cycle while enabled, pulses expired at a count of one
 * and either reloads or stops at zero, the count reads back as one word
 */
module interval_timer
    import bus_map_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  timer_config_t         timer_config,
    input  target_access_t        access,
    output logic                  expired,
    output logic [data_width-1:0] rdata
);

    logic [data_width-1:0] count;
    logic                  at_one;

    assign at_one = (count == data_width'(1));

    // ------------------------------------------------------------------
    // counter
    // ------------------------------------------------------------------

    // a direct write always wins over counting, so software can start a
    // one-shot run without touching the reload value
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            count <= '0;
        end else if (access.write) begin
            count <= access.wdata;
        end else if (timer_config.enable) begin
            if (count == '0) begin
                // a zero count restarts from the reload value in reload mode
                // and otherwise the timer stays stopped
                if (timer_config.reload_mode) begin
                    count <= timer_config.reload_value;
                end
            end else if (at_one && timer_config.reload_mode) begin
                count <= timer_config.reload_value;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // one pulse per run, on the edge that leaves a count of one
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            expired <= 1'b0;
        end else begin
            expired <= timer_config.enable && at_one && !access.write;
        end
    end

    always_ff @(posedge clock) begin
        if (access.read) begin
            rdata <= count;
        end
    end

endmodule

// ==== hw/mapped_bus_top.sv ====
/*
 * mapped strobe bus target
 * ties the sequencer to three region mappers and the RAM, register and
 * timer targets behind them
 */
module mapped_bus_top
    import bus_map_pkg::*;
(
    input  logic          clock,
    input  logic          rst_n,
    input  logic          req,
    input  bus_request_t  request,
    output logic          busy,
    output logic          rsp_valid,
    output bus_response_t response,
    output logic          irq
);

    logic                   lookup_enable;
    logic [addr_width-1:0]  lookup_addr;
    logic                   ram_hit;
    logic                   reg_hit;
    logic                   timer_hit;
    logic [index_width-1:0] ram_index;
    logic [index_width-1:0] reg_index;
    logic [index_width-1:0] timer_index;
    logic [index_width-1:0] lookup_index;
    target_access_t         ram_access;
    target_access_t         reg_access;
    target_access_t         timer_access;
    logic [data_width-1:0]  ram_rdata;
    logic [data_width-1:0]  reg_rdata;
    logic [data_width-1:0]  timer_rdata;
    timer_config_t          timer_config;
    logic                   expired;

    access_sequencer sequencer (
        .clock        (clock),
        .rst_n        (rst_n),
        .req          (req),
        .request      (request),
        .busy         (busy),
        .lookup_enable(lookup_enable),
        .lookup_addr  (lookup_addr),
        .ram_hit      (ram_hit),
        .reg_hit      (reg_hit),
        .timer_hit    (timer_hit),
        .lookup_index (lookup_index),
        .ram_access   (ram_access),
        .reg_access   (reg_access),
        .timer_access (timer_access),
        .ram_rdata    (ram_rdata),
        .reg_rdata    (reg_rdata),
        .timer_rdata  (timer_rdata),
        .rsp_valid    (rsp_valid),
        .response     (response)
    );

    // ------------------------------------------------------------------
    // region mappers
    // ------------------------------------------------------------------

    memory_mapper #(.addr_base(ram_base), .addr_bound(ram_bound)) ram_map (
        .clock(clock), .rst_n(rst_n), .enable(lookup_enable),
        .addr(lookup_addr), .index(ram_index), .hit(ram_hit)
    );

    memory_mapper #(.addr_base(reg_base), .addr_bound(reg_bound)) reg_map (
        .clock(clock), .rst_n(rst_n), .enable(lookup_enable),
        .addr(lookup_addr), .index(reg_index), .hit(reg_hit)
    );

    memory_mapper #(.addr_base(timer_base), .addr_bound(timer_bound)) timer_map (
        .clock(clock), .rst_n(rst_n), .enable(lookup_enable),
        .addr(lookup_addr), .index(timer_index), .hit(timer_hit)
    );

    // a mapper that misses drives a zero index, so OR merges them safely
    assign lookup_index = ram_index | reg_index | timer_index;

    // ------------------------------------------------------------------
    // targets
    // ------------------------------------------------------------------

    scratch_ram ram (
        .clock (clock),
        .access(ram_access),
        .rdata (ram_rdata)
    );

    control_regs regs (
        .clock       (clock),
        .rst_n       (rst_n),
        .access      (reg_access),
        .expired     (expired),
        .rdata       (reg_rdata),
        .timer_config(timer_config),
        .irq         (irq)
    );

    interval_timer timer (
        .clock       (clock),
        .rst_n       (rst_n),
        .timer_config(timer_config),
        .access      (timer_access),
        .expired     (expired),
        .rdata       (timer_rdata)
    );

endmodule

// ==== dv/mapped_bus_assertions.sv ====
/*
 * protocol checks for the mapped strobe bus target
 * watches response timing, the error flag, busy and the expiry interrupt
 */
module mapped_bus_assertions
    import bus_map_pkg::*;
(
    input logic           clock,
    input logic           rst_n,
    input logic           req,
    input bus_request_t   request,
    input logic           busy,
    input logic           rsp_valid,
    input bus_response_t  response,
    input logic           irq,
    input timer_config_t  timer_config,
    input target_access_t reg_access
);
    timeunit 1ns;
    timeprecision 1ps;

    logic accepted;
    logic addr_mapped;
    logic clear_write;
    logic enabled_seen;
    int   failure_count = 0;

    // a request only counts when the sequencer is idle to take it
    assign accepted = req && !busy;

    // region membership straight from the package address map
    assign addr_mapped = (request.addr >= ram_base && request.addr <= ram_bound) ||
                         (request.addr >= reg_base && request.addr <= reg_bound) ||
                         (request.addr >= timer_base && request.addr <= timer_bound);

    // software writing a one to the sticky expiry bit
    assign clear_write = reg_access.write && (reg_access.index == reg_status) &&
                         reg_access.wdata[0];

    // remembers whether the timer has ever been switched on since reset
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            enabled_seen <= 1'b0;
        end else if (timer_config.enable) begin
            enabled_seen <= 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // response timing and busy
    // ------------------------------------------------------------------

    // the response pulse lands on the fourth sampled edge after acceptance
    response_on_time: assert property (@(posedge clock) disable iff (!rst_n)
        $past(accepted, 4) |-> rsp_valid && !busy)
        else begin
            failure_count++;
            $error("no response four cycles after accept");
        end

    // the three cycles in between stay busy with no response
    busy_while_pending: assert property (@(posedge clock) disable iff (!rst_n)
        $past(accepted, 1) || $past(accepted, 2) || $past(accepted, 3) |->
        busy && !rsp_valid)
        else begin
            failure_count++;
            $error("busy dropped or early response");
        end

    // dropped requests must never produce a response of their own
    no_extra_response: assert property (@(posedge clock) disable iff (!rst_n)
        rsp_valid |-> $past(accepted, 4))
        else begin
            failure_count++;
            $error("response without an accepted request");
        end

    busy_ends_with_response: assert property (@(posedge clock) disable iff (!rst_n)
        $fell(busy) |-> rsp_valid)
        else begin
            failure_count++;
            $error("busy fell without a response pulse");
        end

    // ------------------------------------------------------------------
    // error flag and interrupt
    // ------------------------------------------------------------------

    err_matches_map: assert property (@(posedge clock) disable iff (!rst_n)
        rsp_valid |-> response.err == !$past(addr_mapped, 4))
        else begin
            failure_count++;
            $error("err flag disagrees with the address map");
        end

    // with the timer off for two cycles no expiry pulse can be in flight
    irq_clears: assert property (@(posedge clock) disable iff (!rst_n)
        clear_write && !timer_config.enable && !$past(timer_config.enable) |=> !irq)
        else begin
            failure_count++;
            $error("irq still high after clearing write");
        end

    irq_stays_low: assert property (@(posedge clock) disable iff (!rst_n)
        !irq && !timer_config.enable && !$past(timer_config.enable) |=> !irq)
        else begin
            failure_count++;
            $error("irq rose with the timer disabled");
        end

    irq_quiet_before_enable: assert property (@(posedge clock) disable iff (!rst_n)
        !enabled_seen |-> !irq)
        else begin
            failure_count++;
            $error("irq rose before the timer was enabled");
        end

endmodule

bind mapped_bus_top mapped_bus_assertions checks (
    .clock       (clock),
    .rst_n       (rst_n),
    .req         (req),
    .request     (request),
    .busy        (busy),
    .rsp_valid   (rsp_valid),
    .response    (response),
    .irq         (irq),
    .timer_config(timer_config),
    .reg_access  (reg_access)
);

// ==== dv/mapped_bus_tb.sv ====
/*
 * testbench for the mapped strobe bus target
 * runs RAM, register, timer and unmapped accesses and checks the read data
 */
module mapped_bus_tb
    import bus_map_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // about 40 requests of six cycles each, with room for the timer wait
    localparam int cycle_limit = 40 * 6 + 2000;

    logic                  clock;
    logic                  rst_n;
    logic                  req;
    bus_request_t          request;
    logic                  busy;
    logic                  rsp_valid;
    bus_response_t         response;
    logic                  irq;
    logic [31:0]           lfsr_state = 32'hf450;
    logic [data_width-1:0] ram_model [16];
    logic [data_width-1:0] reload_model;
    logic [data_width-1:0] scratch_model;
    logic [data_width-1:0] value;
    logic [data_width-1:0] read_data;
    logic                  read_err;
    logic [addr_width-1:0] addr;
    logic [3:0]            index;
    logic                  write_flag;
    int                    waited;
    int                    total_errors;
    int                    cycle_count = 0;
    int                    check_count = 0;
    int                    error_count = 0;

    mapped_bus_top DUT (
        .clock    (clock),
        .rst_n    (rst_n),
        .req      (req),
        .request  (request),
        .busy     (busy),
        .rsp_valid(rsp_valid),
        .response (response),
        .irq      (irq)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // hard stop in case the DUT never answers
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the test sequence never finished", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return bits;
    endfunction

    function automatic logic in_map(input logic [addr_width-1:0] a);
        return (a >= ram_base && a <= ram_bound) || (a >= reg_base && a <= reg_bound) ||
               (a >= timer_base && a <= timer_bound);
    endfunction

    // one full bus cycle, optionally pulsing a stray read while busy
    task automatic bus_access(input logic write, input logic [addr_width-1:0] a,
                              input logic [data_width-1:0] wdata, input logic poke_busy,
                              output logic [data_width-1:0] data_out, output logic err_out);
        @(posedge clock);
        req           <= 1'b1;
        request.write <= write;
        request.addr  <= a;
        request.wdata <= wdata;
        @(posedge clock);
        req <= 1'b0;
        if (poke_busy) begin
            @(posedge clock);
            req           <= 1'b1;
            request.write <= 1'b0;
            request.addr  <= 12'hfff;
            @(posedge clock);
            req <= 1'b0;
        end
        do @(posedge clock); while (!rsp_valid);
        data_out = response.rdata;
        err_out  = response.err;
    endtask

    task automatic check_equal(input string name, input logic [data_width-1:0] expected,
                               input logic [data_width-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_at_most(input string name, input logic [data_width-1:0] limit,
                                 input logic [data_width-1:0] actual);
        check_count++;
        if ($isunknown(actual) || actual > limit) begin
            error_count++;
            $display("FAILED %s expected at most %h actual %h", name, limit, actual);
        end
    endtask

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------

    initial begin
        rst_n   = 1'b0;
        req     = 1'b0;
        request = '0;
        repeat (10) @(posedge clock);
        rst_n <= 1'b1;

        // fill every RAM word, then overwrite a few at random
        for (int i = 0; i < 16; i++) begin
            value        = 16'(random_bits(16));
            ram_model[i] = value;
            bus_access(1'b1, ram_base + 12'(i), value, 1'b0, read_data, read_err);
            check_equal("ram write err", 16'(1'b0), 16'(read_err));
        end
        for (int i = 0; i < 4; i++) begin
            index            = 4'(random_bits(4));
            value            = 16'(random_bits(16));
            ram_model[index] = value;
            bus_access(1'b1, ram_base + 12'(index), value, 1'b0, read_data, read_err);
        end
        for (int i = 0; i < 8; i++) begin
            index = 4'(random_bits(4));
            bus_access(1'b0, ram_base + 12'(index), '0, 1'b0, read_data, read_err);
            check_equal("ram read", ram_model[index], read_data);
            check_equal("ram read err", 16'(1'b0), 16'(read_err));
        end

        // unmapped addresses, the first one also pokes req while busy
        for (int i = 0; i < 4; i++) begin
            do addr = 12'(random_bits(12)); while (in_map(addr));
            write_flag = random_bits(1) != 0;
            bus_access(write_flag, addr, 16'(random_bits(16)), i == 0, read_data, read_err);
            check_equal("unmapped err", 16'(1'b1), 16'(read_err));
        end

        // scratch at index 3 must leave the reload register alone
        reload_model = 16'(random_bits(16));
        bus_access(1'b1, reg_base + 12'(reg_timer_reload), reload_model, 1'b0, read_data, read_err);
        scratch_model = 16'(random_bits(16));
        bus_access(1'b1, reg_base + 12'(reg_scratch), scratch_model, 1'b0, read_data, read_err);
        bus_access(1'b0, reg_base + 12'(reg_scratch), '0, 1'b0, read_data, read_err);
        check_equal("scratch read", scratch_model, read_data);
        bus_access(1'b0, reg_base + 12'(reg_timer_reload), '0, 1'b0, read_data, read_err);
        check_equal("reload after scratch write", reload_model, read_data);

        // periodic timer with a reload of 20
        bus_access(1'b1, reg_base + 12'(reg_timer_reload), 16'd20, 1'b0, read_data, read_err);
        bus_access(1'b1, reg_base + 12'(reg_timer_ctrl), 16'h0003, 1'b0, read_data, read_err);
        waited = 0;
        while (!irq && waited < 100) begin
            @(posedge clock);
            waited++;
        end
        if (!irq) begin
            error_count++;
            $display("irq did not rise within 100 cycles of enabling the timer");
        end
        bus_access(1'b0, timer_base, '0, 1'b0, read_data, read_err);
        check_at_most("timer count", 16'd20, read_data);

        // stop the timer, then clear the sticky flag
        bus_access(1'b1, reg_base + 12'(reg_timer_ctrl), 16'h0000, 1'b0, read_data, read_err);
        bus_access(1'b1, reg_base + 12'(reg_status), 16'h0001, 1'b0, read_data, read_err);
        bus_access(1'b0, reg_base + 12'(reg_status), '0, 1'b0, read_data, read_err);
        check_equal("status after clear", 16'h0000, read_data);
        check_equal("irq after clear", 16'(1'b0), 16'(irq));
        repeat (30) @(posedge clock);

        total_errors = error_count + DUT.checks.failure_count;
        $display("checks %0d, data errors %0d, assertion failures %0d",
                 check_count, error_count, DUT.checks.failure_count);
        if (total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hw/bus_map_pkg.sv
hw/memory_mapper.sv
hw/access_sequencer.sv
hw/scratch_ram.sv
hw/control_regs.sv
hw/interval_timer.sv
hw/mapped_bus_top.sv
dv/mapped_bus_assertions.sv
dv/mapped_bus_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the mapped bus testbench with Verilator and runs it
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module mapped_bus_tb -f files.f -o mapped_bus_sim

./obj_dir/mapped_bus_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "Test FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"
